// File: design/scr1_dmem_pkg.sv
// Shared widths, encodings, structs and address map, referenced by scoped name in RTL and DV
package scr1_dmem_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int unsigned XLEN = 32;
    localparam int unsigned BE_W = 4;           // One enable per byte lane

    // ----------------------------------------
    // Memory protocol encodings
    // ----------------------------------------
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE = 2'b00,
        MEM_WIDTH_HALF = 2'b01,
        MEM_WIDTH_WORD = 2'b10
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_IDLE   = 2'b00,                // No response this cycle
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    typedef struct packed {
        mem_cmd_e        cmd;
        mem_width_e      width;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;                 // LSB aligned from requester
    } dmem_req_t;

    typedef struct packed {
        mem_resp_e       resp;
        logic [XLEN-1:0] rdata;
    } dmem_rsp_t;

    // Wishbone master side and slave side
    typedef struct packed {
        logic            stb;
        logic [XLEN-1:0] adr;
        logic            we;
        logic [XLEN-1:0] dat;
        logic [BE_W-1:0] sel;
    } wb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] dat;
        logic            ack;
        logic            err;
    } wb_rsp_t;

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    localparam logic [XLEN-1:0] TCM_ADDR_MASK      = 32'hFFFF_F000;
    localparam logic [XLEN-1:0] TCM_ADDR_PATTERN   = 32'h0048_0000;
    localparam int unsigned     TCM_WORDS          = 1024;
    localparam logic [XLEN-1:0] TIMER_ADDR_MASK    = 32'hFFFF_FFE0;
    localparam logic [XLEN-1:0] TIMER_ADDR_PATTERN = 32'h0049_0000;

    // Timer register offsets within its 32-byte window
    localparam logic [4:0] TIMER_OFS_CTRL     = 5'h00;  // Bit 0 is enable
    localparam logic [4:0] TIMER_OFS_MTIME_LO = 5'h08;
    localparam logic [4:0] TIMER_OFS_MTIME_HI = 5'h0C;
    localparam logic [4:0] TIMER_OFS_CMP_LO   = 5'h10;
    localparam logic [4:0] TIMER_OFS_CMP_HI   = 5'h14;

    typedef enum logic [1:0] {
        PORT_TCM   = 2'd0,
        PORT_TIMER = 2'd1,
        PORT_WB    = 2'd2                       // Default target
    } port_sel_e;

    // Byte lanes touched by an access of given width and low address bits
    function automatic logic [BE_W-1:0] byte_en(mem_width_e width, logic [1:0] addr_lo);
        case (width)
            MEM_WIDTH_BYTE: return 4'b0001 << addr_lo;
            MEM_WIDTH_HALF: return addr_lo[1] ? 4'b1100 : 4'b0011;
            default:        return 4'b1111;
        endcase
    endfunction

    // Copy LSB-aligned write data into every lane it may land on
    function automatic logic [XLEN-1:0] wdata_lanes(mem_width_e width, logic [XLEN-1:0] wdata);
        case (width)
            MEM_WIDTH_BYTE: return {4{wdata[7:0]}};
            MEM_WIDTH_HALF: return {2{wdata[15:0]}};
            default:        return wdata;
        endcase
    endfunction

endpackage

// File: design/scr1_dmem_router.sv
// Data request router, decodes the address and steers one outstanding request to TCM, timer or WB
`timescale 1ns/1ps

module scr1_dmem_router (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Requester side
    input  logic                    core_req_i,
    output logic                    core_req_ack_o,
    input  scr1_dmem_pkg::dmem_req_t core_cmd_i,
    output scr1_dmem_pkg::dmem_rsp_t core_rsp_o,
    // TCM port
    output logic                    tcm_req_o,
    input  logic                    tcm_req_ack_i,
    output scr1_dmem_pkg::dmem_req_t tcm_cmd_o,
    input  scr1_dmem_pkg::dmem_rsp_t tcm_rsp_i,
    // Timer port
    output logic                    timer_req_o,
    input  logic                    timer_req_ack_i,
    output scr1_dmem_pkg::dmem_req_t timer_cmd_o,
    input  scr1_dmem_pkg::dmem_rsp_t timer_rsp_i,
    // WB bridge port
    output logic                    wb_req_o,
    input  logic                    wb_req_ack_i,
    output scr1_dmem_pkg::dmem_req_t wb_cmd_o,
    input  scr1_dmem_pkg::dmem_rsp_t wb_rsp_i
);

    logic                      hit_tcm;
    logic                      hit_timer;
    scr1_dmem_pkg::port_sel_e  sel_d;         // Target of the current request
    scr1_dmem_pkg::port_sel_e  sel_q;         // Target of the outstanding request
    logic                      busy_q;        // Waiting for a response
    logic                      tgt_ack;
    logic                      fwd;
    logic                      accept;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign hit_tcm   = (core_cmd_i.addr & scr1_dmem_pkg::TCM_ADDR_MASK)
                       == scr1_dmem_pkg::TCM_ADDR_PATTERN;
    assign hit_timer = (core_cmd_i.addr & scr1_dmem_pkg::TIMER_ADDR_MASK)
                       == scr1_dmem_pkg::TIMER_ADDR_PATTERN;

    assign sel_d = hit_tcm   ? scr1_dmem_pkg::PORT_TCM   :
                   hit_timer ? scr1_dmem_pkg::PORT_TIMER :
                               scr1_dmem_pkg::PORT_WB;

    always_comb begin
        case (sel_d)
            scr1_dmem_pkg::PORT_TCM:   tgt_ack = tcm_req_ack_i;
            scr1_dmem_pkg::PORT_TIMER: tgt_ack = timer_req_ack_i;
            default:                   tgt_ack = wb_req_ack_i;
        endcase
    end

    // Ack only while idle, caller holds req otherwise
    assign core_req_ack_o = ~busy_q & tgt_ack;
    assign fwd            = core_req_i & ~busy_q;
    assign accept         = fwd & tgt_ack;

    assign tcm_req_o   = fwd & (sel_d == scr1_dmem_pkg::PORT_TCM);
    assign timer_req_o = fwd & (sel_d == scr1_dmem_pkg::PORT_TIMER);
    assign wb_req_o    = fwd & (sel_d == scr1_dmem_pkg::PORT_WB);

    // Payload broadcast, qualified by each req
    assign tcm_cmd_o   = core_cmd_i;
    assign timer_cmd_o = core_cmd_i;
    assign wb_cmd_o    = core_cmd_i;

    // ----------------------------------------
    // Response return
    // ----------------------------------------
    always_comb begin
        core_rsp_o.resp  = scr1_dmem_pkg::MEM_RESP_IDLE;
        core_rsp_o.rdata = '0;
        if (busy_q) begin
            case (sel_q)
                scr1_dmem_pkg::PORT_TCM:   core_rsp_o = tcm_rsp_i;
                scr1_dmem_pkg::PORT_TIMER: core_rsp_o = timer_rsp_i;
                default:                   core_rsp_o = wb_rsp_i;
            endcase
        end
    end

    // Idle/waiting state and latched target
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            sel_q  <= scr1_dmem_pkg::PORT_WB;
        end else if (accept) begin
            busy_q <= 1'b1;
            sel_q  <= sel_d;
        end else if (busy_q && core_rsp_o.resp != scr1_dmem_pkg::MEM_RESP_IDLE) begin
            busy_q <= 1'b0;                   // Back to idle after the resp pulse
        end
    end

endmodule

// File: design/scr1_tcm.sv
// Tightly coupled data memory, word organized, byte enabled writes, one cycle response
`timescale 1ns/1ps

module scr1_tcm (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     req_i,
    output logic                     req_ack_o,
    input  scr1_dmem_pkg::dmem_req_t cmd_i,
    output scr1_dmem_pkg::dmem_rsp_t rsp_o
);

    logic [scr1_dmem_pkg::XLEN-1:0] mem [scr1_dmem_pkg::TCM_WORDS];
    logic [9:0]                     idx;      // Word index, address bits 11:2
    logic [scr1_dmem_pkg::BE_W-1:0] be;
    logic [scr1_dmem_pkg::XLEN-1:0] wr_lanes;
    logic [scr1_dmem_pkg::XLEN-1:0] merged;   // Stored word after this access
    logic                           is_wr;
    scr1_dmem_pkg::mem_resp_e       resp_q;
    logic [scr1_dmem_pkg::XLEN-1:0] rdata_q;

    assign req_ack_o = 1'b1;                  // Never stalls
    assign idx       = cmd_i.addr[11:2];
    assign is_wr     = cmd_i.cmd == scr1_dmem_pkg::MEM_CMD_WR;
    assign be        = scr1_dmem_pkg::byte_en(cmd_i.width, cmd_i.addr[1:0]);
    assign wr_lanes  = scr1_dmem_pkg::wdata_lanes(cmd_i.width, cmd_i.wdata);

    // Per lane select between new and old byte
    always_comb begin
        for (int b = 0; b < scr1_dmem_pkg::BE_W; b++) begin
            merged[8*b +: 8] = (is_wr && be[b]) ? wr_lanes[8*b +: 8] : mem[idx][8*b +: 8];
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (is_wr) begin
                mem[idx] <= merged;
            end
            rdata_q <= merged;                // New content on a write
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            resp_q <= scr1_dmem_pkg::MEM_RESP_IDLE;
        end else begin
            resp_q <= req_i ? scr1_dmem_pkg::MEM_RESP_RDY_OK : scr1_dmem_pkg::MEM_RESP_IDLE;
        end
    end

    assign rsp_o.resp  = resp_q;
    assign rsp_o.rdata = rdata_q;

endmodule

// File: design/scr1_timer.sv
// Memory-mapped machine timer, 64-bit mtime and mtimecmp with enable and level interrupt
`timescale 1ns/1ps

module scr1_timer (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     req_i,
    output logic                     req_ack_o,
    input  scr1_dmem_pkg::dmem_req_t cmd_i,
    output scr1_dmem_pkg::dmem_rsp_t rsp_o,
    output logic [63:0]              timer_val_o,
    output logic                     timer_irq_o
);

    logic                           en_q;     // Count enable
    logic [63:0]                    mtime_q;
    logic [63:0]                    mtimecmp_q;
    logic                           irq_q;
    logic [4:0]                     ofs;
    logic                           reg_ok;   // Word access to a listed offset
    logic                           wr_en;
    logic [scr1_dmem_pkg::XLEN-1:0] rd_word;
    scr1_dmem_pkg::mem_resp_e       resp_q;
    logic [scr1_dmem_pkg::XLEN-1:0] rdata_q;

    assign req_ack_o = 1'b1;
    assign ofs       = cmd_i.addr[4:0];

    // ----------------------------------------
    // Register decode
    // ----------------------------------------
    always_comb begin
        reg_ok  = 1'b1;
        rd_word = '0;
        case (ofs)
            scr1_dmem_pkg::TIMER_OFS_CTRL:     rd_word = scr1_dmem_pkg::XLEN'(en_q);
            scr1_dmem_pkg::TIMER_OFS_MTIME_LO: rd_word = mtime_q[31:0];
            scr1_dmem_pkg::TIMER_OFS_MTIME_HI: rd_word = mtime_q[63:32];
            scr1_dmem_pkg::TIMER_OFS_CMP_LO:   rd_word = mtimecmp_q[31:0];
            scr1_dmem_pkg::TIMER_OFS_CMP_HI:   rd_word = mtimecmp_q[63:32];
            default:                           reg_ok  = 1'b0;
        endcase
        if (cmd_i.width != scr1_dmem_pkg::MEM_WIDTH_WORD) begin
            reg_ok = 1'b0;                    // Word access only
        end
    end

    assign wr_en = req_i & reg_ok & (cmd_i.cmd == scr1_dmem_pkg::MEM_CMD_WR);

    // ----------------------------------------
    // Counter, compare and interrupt
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q       <= 1'b0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;                 // No interrupt out of reset
            irq_q      <= 1'b0;
        end else begin
            irq_q <= mtime_q >= mtimecmp_q;
            if (wr_en && ofs == scr1_dmem_pkg::TIMER_OFS_CTRL) begin
                en_q <= cmd_i.wdata[0];
            end
            // Software write wins over the increment
            if (wr_en && ofs == scr1_dmem_pkg::TIMER_OFS_MTIME_LO) begin
                mtime_q[31:0] <= cmd_i.wdata;
            end else if (wr_en && ofs == scr1_dmem_pkg::TIMER_OFS_MTIME_HI) begin
                mtime_q[63:32] <= cmd_i.wdata;
            end else if (en_q) begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (wr_en && ofs == scr1_dmem_pkg::TIMER_OFS_CMP_LO) begin
                mtimecmp_q[31:0] <= cmd_i.wdata;
            end
            if (wr_en && ofs == scr1_dmem_pkg::TIMER_OFS_CMP_HI) begin
                mtimecmp_q[63:32] <= cmd_i.wdata;
            end
        end
    end

    // Response one cycle after acceptance
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            resp_q <= scr1_dmem_pkg::MEM_RESP_IDLE;
        end else if (req_i) begin
            resp_q <= reg_ok ? scr1_dmem_pkg::MEM_RESP_RDY_OK : scr1_dmem_pkg::MEM_RESP_RDY_ER;
        end else begin
            resp_q <= scr1_dmem_pkg::MEM_RESP_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_q <= rd_word;               // Value before any write
        end
    end

    assign rsp_o.resp  = resp_q;
    assign rsp_o.rdata = rdata_q;
    assign timer_val_o = mtime_q;
    assign timer_irq_o = irq_q;

endmodule

// File: design/scr1_dmem_wb.sv
// Bridge from the data memory protocol to single Wishbone strobe/ack/err cycles
`timescale 1ns/1ps

module scr1_dmem_wb (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     req_i,
    output logic                     req_ack_o,
    input  scr1_dmem_pkg::dmem_req_t cmd_i,
    output scr1_dmem_pkg::dmem_rsp_t rsp_o,
    output scr1_dmem_pkg::wb_req_t   wb_o,
    input  scr1_dmem_pkg::wb_rsp_t   wb_i
);

    logic                           stb_q;    // Bus cycle open
    logic                           start;
    logic                           done;     // Slave ends the cycle
    logic [scr1_dmem_pkg::XLEN-1:0] adr_q;
    logic                           we_q;
    logic [scr1_dmem_pkg::XLEN-1:0] dat_q;
    logic [scr1_dmem_pkg::BE_W-1:0] sel_q;
    scr1_dmem_pkg::mem_resp_e       resp_q;
    logic [scr1_dmem_pkg::XLEN-1:0] rdata_q;

    assign req_ack_o = ~stb_q;                // One bus cycle at a time
    assign start     = req_i & ~stb_q;
    assign done      = stb_q & (wb_i.ack | wb_i.err);

    // ----------------------------------------
    // Cycle control
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stb_q  <= 1'b0;
            resp_q <= scr1_dmem_pkg::MEM_RESP_IDLE;
        end else begin
            if (start) begin
                stb_q <= 1'b1;
            end else if (done) begin
                stb_q <= 1'b0;
            end
            if (done) begin
                resp_q <= wb_i.err ? scr1_dmem_pkg::MEM_RESP_RDY_ER
                                   : scr1_dmem_pkg::MEM_RESP_RDY_OK;
            end else begin
                resp_q <= scr1_dmem_pkg::MEM_RESP_IDLE;
            end
        end
    end

    // Bus payload and read data
    always_ff @(posedge clk_i) begin
        if (start) begin
            adr_q <= {cmd_i.addr[scr1_dmem_pkg::XLEN-1:2], 2'b00};   // Word aligned
            we_q  <= cmd_i.cmd == scr1_dmem_pkg::MEM_CMD_WR;
            dat_q <= scr1_dmem_pkg::wdata_lanes(cmd_i.width, cmd_i.wdata);
            sel_q <= scr1_dmem_pkg::byte_en(cmd_i.width, cmd_i.addr[1:0]);
        end
        if (done) begin
            rdata_q <= wb_i.dat;
        end
    end

    assign wb_o.stb = stb_q;
    assign wb_o.adr = adr_q;
    assign wb_o.we  = we_q;
    assign wb_o.dat = dat_q;
    assign wb_o.sel = sel_q;

    assign rsp_o.resp  = resp_q;
    assign rsp_o.rdata = rdata_q;

endmodule

// File: design/scr1_dmem_top.sv
// Data memory subsystem top, router with TCM, machine timer and Wishbone bridge behind it
`timescale 1ns/1ps

module scr1_dmem_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    // Data request port
    input  logic                     req_i,
    output logic                     req_ack_o,
    input  scr1_dmem_pkg::dmem_req_t cmd_i,
    output scr1_dmem_pkg::dmem_rsp_t rsp_o,
    // External Wishbone
    output scr1_dmem_pkg::wb_req_t   wb_o,
    input  scr1_dmem_pkg::wb_rsp_t   wb_i,
    // Timer
    output logic [63:0]              timer_val_o,
    output logic                     timer_irq_o
);

    // ----------------------------------------
    // Router to target links
    // ----------------------------------------
    logic                     tcm_req;
    logic                     tcm_req_ack;
    scr1_dmem_pkg::dmem_req_t tcm_cmd;
    scr1_dmem_pkg::dmem_rsp_t tcm_rsp;

    logic                     timer_req;
    logic                     timer_req_ack;
    scr1_dmem_pkg::dmem_req_t timer_cmd;
    scr1_dmem_pkg::dmem_rsp_t timer_rsp;

    logic                     wb_req;         // Default target
    logic                     wb_req_ack;
    scr1_dmem_pkg::dmem_req_t wb_cmd;
    scr1_dmem_pkg::dmem_rsp_t wb_rsp;

    scr1_dmem_router i_router (
        .clk_i           (clk_i        ),
        .rst_n_i         (rst_n_i      ),
        .core_req_i      (req_i        ),
        .core_req_ack_o  (req_ack_o    ),
        .core_cmd_i      (cmd_i        ),
        .core_rsp_o      (rsp_o        ),
        .tcm_req_o       (tcm_req      ),
        .tcm_req_ack_i   (tcm_req_ack  ),
        .tcm_cmd_o       (tcm_cmd      ),
        .tcm_rsp_i       (tcm_rsp      ),
        .timer_req_o     (timer_req    ),
        .timer_req_ack_i (timer_req_ack),
        .timer_cmd_o     (timer_cmd    ),
        .timer_rsp_i     (timer_rsp    ),
        .wb_req_o        (wb_req       ),
        .wb_req_ack_i    (wb_req_ack   ),
        .wb_cmd_o        (wb_cmd       ),
        .wb_rsp_i        (wb_rsp       )
    );

    scr1_tcm i_tcm (
        .clk_i     (clk_i      ),
        .rst_n_i   (rst_n_i    ),
        .req_i     (tcm_req    ),
        .req_ack_o (tcm_req_ack),
        .cmd_i     (tcm_cmd    ),
        .rsp_o     (tcm_rsp    )
    );

    scr1_timer i_timer (
        .clk_i       (clk_i        ),
        .rst_n_i     (rst_n_i      ),
        .req_i       (timer_req    ),
        .req_ack_o   (timer_req_ack),
        .cmd_i       (timer_cmd    ),
        .rsp_o       (timer_rsp    ),
        .timer_val_o (timer_val_o  ),
        .timer_irq_o (timer_irq_o  )
    );

    scr1_dmem_wb i_dmem_wb (
        .clk_i     (clk_i     ),
        .rst_n_i   (rst_n_i   ),
        .req_i     (wb_req    ),
        .req_ack_o (wb_req_ack),
        .cmd_i     (wb_cmd    ),
        .rsp_o     (wb_rsp    ),
        .wb_o      (wb_o      ),
        .wb_i      (wb_i      )
    );

endmodule

// File: dv/wb_mem_model.sv
// Wishbone slave memory for the testbench, acks two cycles after stb and errors in the 0xF region
`timescale 1ns/1ps

module wb_mem_model (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  scr1_dmem_pkg::wb_req_t wb_i,
    output scr1_dmem_pkg::wb_rsp_t wb_o
);

    logic [31:0] mem [256];                   // Aliases every 1 KiB
    logic [7:0]  idx;
    logic [1:0]  wait_q;                      // Cycles stb has been seen
    logic        hit_err;

    assign idx     = wb_i.adr[9:2];
    assign hit_err = wb_i.adr[31:28] == 4'hF;

    // Fill derived from the word index
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hC0DE_0000 | i;
        end
    end

    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_q   <= 2'd0;
            wb_o.ack <= 1'b0;
            wb_o.err <= 1'b0;
            wb_o.dat <= '0;
        end else if (wb_o.ack || wb_o.err) begin
            wb_o.ack <= 1'b0;                 // Single cycle ack or err
            wb_o.err <= 1'b0;
            wait_q   <= 2'd0;
        end else if (wb_i.stb) begin
            if (wait_q == 2'd1) begin
                wb_o.ack <= ~hit_err;
                wb_o.err <= hit_err;
                wb_o.dat <= mem[idx];
                if (wb_i.we && !hit_err) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_i.sel[b]) begin
                            mem[idx][8*b +: 8] <= wb_i.dat[8*b +: 8];
                        end
                    end
                end
            end else begin
                wait_q <= wait_q + 2'd1;
            end
        end
    end

endmodule

// File: dv/tb_scr1_dmem.sv
// Directed testbench that drives the data memory request port and checks every target
`timescale 1ns/1ps

module tb_scr1_dmem;

    localparam int TIMEOUT_CYC = 200;         // Bound on every wait loop

    logic                            clk;
    logic                            rst_n;
    logic                            req;
    logic                            req_ack;
    scr1_dmem_pkg::dmem_req_t        cmd;
    scr1_dmem_pkg::dmem_rsp_t        rsp;
    scr1_dmem_pkg::wb_req_t          wb_req;
    scr1_dmem_pkg::wb_rsp_t          wb_rsp;
    logic [63:0]                     timer_val;
    logic                            timer_irq;
    logic [31:0]                     lcg_state = 32'd14769;
    int                              checks = 0;
    int                              errors = 0;

    scr1_dmem_top scr1_dmem_top_inst (
        .clk_i       (clk      ),
        .rst_n_i     (rst_n    ),
        .req_i       (req      ),
        .req_ack_o   (req_ack  ),
        .cmd_i       (cmd      ),
        .rsp_o       (rsp      ),
        .wb_o        (wb_req   ),
        .wb_i        (wb_rsp   ),
        .timer_val_o (timer_val),
        .timer_irq_o (timer_irq)
    );

    wb_mem_model wb_mem (
        .clk_i   (clk   ),
        .rst_n_i (rst_n ),
        .wb_i    (wb_req),
        .wb_o    (wb_rsp)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_resp(input scr1_dmem_pkg::mem_resp_e got,
                              input scr1_dmem_pkg::mem_resp_e exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @%0t: %s, resp %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input logic [scr1_dmem_pkg::XLEN-1:0] got,
                              input logic [scr1_dmem_pkg::XLEN-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @%0t: %s, data %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_irq(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @%0t: %s, irq %b expected %b", $time, what, got, exp);
        end
    endtask

    // Hold req until accepted and then wait for the resp pulse
    task automatic access(input scr1_dmem_pkg::mem_cmd_e c, input scr1_dmem_pkg::mem_width_e w,
                          input logic [31:0] a, input logic [31:0] wd,
                          output scr1_dmem_pkg::mem_resp_e r, output logic [31:0] rd);
        scr1_dmem_pkg::dmem_req_t q;
        int                       n;
        logic                     got;
        q.cmd   = c;
        q.width = w;
        q.addr  = a;
        q.wdata = wd;
        r       = scr1_dmem_pkg::MEM_RESP_IDLE;
        rd      = '0;
        n       = 0;
        got     = 1'b0;
        @(posedge clk);
        req <= 1'b1;
        cmd <= q;
        while (!got && n < TIMEOUT_CYC) begin
            @(negedge clk);                   // Mid cycle sample
            if (req_ack) begin
                got = 1'b1;
            end else begin
                n++;
            end
        end
        @(posedge clk);                       // Acceptance edge
        req <= 1'b0;
        if (!got) begin
            errors++;
            $display("Timeout at %0t: request to %h was never accepted", $time, a);
        end else begin
            got = 1'b0;
            n   = 0;
            while (!got && n < TIMEOUT_CYC) begin
                @(negedge clk);
                if (rsp.resp != scr1_dmem_pkg::MEM_RESP_IDLE) begin
                    got = 1'b1;
                    r   = rsp.resp;
                    rd  = rsp.rdata;
                end else begin
                    n++;
                end
            end
            if (!got) begin
                errors++;
                $display("Timeout at %0t: no response for request to %h", $time, a);
            end
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("%-12s finished with %0d errors", name, errors - err0);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic reset_values();
        int err0;
        err0 = errors;
        @(negedge clk);
        check_resp(rsp.resp, scr1_dmem_pkg::MEM_RESP_IDLE, "resp after reset");
        check_data({31'b0, wb_req.stb}, '0, "wb stb after reset");
        check_irq(timer_irq, 1'b0, "irq after reset");
        check_data(timer_val[31:0], '0, "mtime lo after reset");
        check_data(timer_val[63:32], '0, "mtime hi after reset");
        report_test("reset", err0);
    endtask

    task automatic tcm_rw_merge();
        int                        err0;
        logic [31:0]               a;
        logic [31:0]               d;
        logic [31:0]               rd;
        scr1_dmem_pkg::mem_resp_e  r;
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            a = scr1_dmem_pkg::TCM_ADDR_PATTERN | (next_rand() & 32'h0000_0FFC);
            d = next_rand();
            access(scr1_dmem_pkg::MEM_CMD_WR, scr1_dmem_pkg::MEM_WIDTH_WORD, a, d, r, rd);
            check_resp(r, scr1_dmem_pkg::MEM_RESP_RDY_OK, "tcm word write");
            access(scr1_dmem_pkg::MEM_CMD_RD, scr1_dmem_pkg::MEM_WIDTH_WORD, a, '0, r, rd);
            check_resp(r, scr1_dmem_pkg::MEM_RESP_RDY_OK, "tcm word read");
            check_data(rd, d, "tcm word read data");
        end
        // Byte into lane 1, then half into upper lanes
        a = 32'h0048_0100;
        access(scr1_dmem_pkg::MEM_CMD_WR, scr1_dmem_pkg::MEM_WIDTH_WORD, a, 32'h1122_3344, r, rd);
        access(scr1_dmem_pkg::MEM_CMD_WR, scr1_dmem_pkg::MEM_WIDTH_BYTE, a + 1, 32'hAB, r, rd);
        check_data(rd, 32'h1122_AB44, "tcm byte merge");
        access(scr1_dmem_pkg::MEM_CMD_WR, scr1_dmem_pkg::MEM_WIDTH_HALF, a + 2, 32'hCDEF, r, rd);
        access(scr1_dmem_pkg::MEM_CMD_RD, scr1_dmem_pkg::MEM_WIDTH_WORD, a, '0, r, rd);
        check_resp(r, scr1_dmem_pkg::MEM_RESP_RDY_OK, "tcm merged read");
        check_data(rd, 32'hCDEF_AB44, "tcm half merge");
        report_test("tcm", err0);
    endtask

    task automatic wishbone_rw();
        int                        err0;
        logic [31:0]               a;
        logic [31:0]               rd;
        scr1_dmem_pkg::mem_resp_e  r;
        err0 = errors;
        a    = 32'h2000_0040;                 // Outside TCM and timer windows
        access(scr1_dmem_pkg::MEM_CMD_WR, scr1_dmem_pkg::MEM_WIDTH_WORD, a, 32'hDEAD_BEEF, r, rd);
        check_resp(r, scr1_dmem_pkg::MEM_RESP_RDY_OK, "wb word write");
        access(scr1_dmem_pkg::MEM_CMD_RD, scr1_dmem_pkg::MEM_WIDTH_WORD, a, '0, r, rd);
        check_resp(r, scr1_dmem_pkg::MEM_RESP_RDY_OK, "wb word read");
        check_data(rd, 32'hDEAD_BEEF, "wb word read data");
        // Only sel lane 3 may change
        access(scr1_dmem_pkg::MEM_CMD_WR, scr1_dmem_pkg::MEM_WIDTH_BYTE, a + 3, 32'h5A, r, rd);
        check_resp(r, scr1_dmem_pkg::MEM_RESP_RDY_OK, "wb byte write");
        access(scr1_dmem_pkg::MEM_CMD_RD, scr1_dmem_pkg::MEM_WIDTH_WORD, a, '0, r, rd);
        check_data(rd, 32'h5AAD_BEEF, "wb byte lane select");
        access(scr1_dmem_pkg::MEM_CMD_RD, scr1_dmem_pkg::MEM_WIDTH_WORD, 32'hF000_0010, '0, r, rd);
        check_resp(r, scr1_dmem_pkg::MEM_RESP_RDY_ER, "wb error region");
        report_test("wishbone", err0);
    endtask

    task automatic count_and_irq();
        int                        err0;
        int                        n;
        logic [31:0]               t;
        logic [31:0]               v1;
        logic [31:0]               v2;
        logic [31:0]               rd;
        scr1_dmem_pkg::mem_resp_e  r;
        err0 = errors;
        t    = scr1_dmem_pkg::TIMER_ADDR_PATTERN;
        access(scr1_dmem_pkg::MEM_CMD_WR, scr1_dmem_pkg::MEM_WIDTH_WORD,
               t | scr1_dmem_pkg::TIMER_OFS_MTIME_LO, '0, r, rd);
        check_resp(r, scr1_dmem_pkg::MEM_RESP_RDY_OK, "mtime lo write");
        access(scr1_dmem_pkg::MEM_CMD_WR, scr1_dmem_pkg::MEM_WIDTH_WORD,
               t | scr1_dmem_pkg::TIMER_OFS_CTRL, 32'd1, r, rd);
        check_resp(r, scr1_dmem_pkg::MEM_RESP_RDY_OK, "timer enable");
        access(scr1_dmem_pkg::MEM_CMD_RD, scr1_dmem_pkg::MEM_WIDTH_WORD,
               t | scr1_dmem_pkg::TIMER_OFS_MTIME_LO, '0, r, v1);
        access(scr1_dmem_pkg::MEM_CMD_RD, scr1_dmem_pkg::MEM_WIDTH_WORD,
               t | scr1_dmem_pkg::TIMER_OFS_MTIME_LO, '0, r, v2);
        checks++;
        if (v2 <= v1) begin
            errors++;
            $display("FAIL @%0t: mtime not increasing, %0d then %0d", $time, v1, v2);
        end
        // Compare value 20 with hi written first to avoid an early match
        access(scr1_dmem_pkg::MEM_CMD_WR, scr1_dmem_pkg::MEM_WIDTH_WORD,
               t | scr1_dmem_pkg::TIMER_OFS_CMP_HI, '0, r, rd);
        access(scr1_dmem_pkg::MEM_CMD_WR, scr1_dmem_pkg::MEM_WIDTH_WORD,
               t | scr1_dmem_pkg::TIMER_OFS_CMP_LO, 32'd20, r, rd);
        n = 0;
        while (!timer_irq && n < TIMEOUT_CYC) begin
            @(negedge clk);
            n++;
        end
        check_irq(timer_irq, 1'b1, "irq after small mtimecmp");
        access(scr1_dmem_pkg::MEM_CMD_WR, scr1_dmem_pkg::MEM_WIDTH_WORD,
               t | scr1_dmem_pkg::TIMER_OFS_CMP_HI, 32'hFFFF_FFFF, r, rd);
        n = 0;
        while (timer_irq && n < TIMEOUT_CYC) begin
            @(negedge clk);
            n++;
        end
        check_irq(timer_irq, 1'b0, "irq after large mtimecmp");
        report_test("timer", err0);
    endtask

    task automatic timer_access_rules();
        int                        err0;
        logic [31:0]               t;
        logic [31:0]               rd;
        scr1_dmem_pkg::mem_resp_e  r;
        err0 = errors;
        t    = scr1_dmem_pkg::TIMER_ADDR_PATTERN;
        access(scr1_dmem_pkg::MEM_CMD_WR, scr1_dmem_pkg::MEM_WIDTH_BYTE,
               t | scr1_dmem_pkg::TIMER_OFS_CTRL, '0, r, rd);
        check_resp(r, scr1_dmem_pkg::MEM_RESP_RDY_ER, "timer byte access");
        access(scr1_dmem_pkg::MEM_CMD_RD, scr1_dmem_pkg::MEM_WIDTH_WORD, t | 32'h04, '0, r, rd);
        check_resp(r, scr1_dmem_pkg::MEM_RESP_RDY_ER, "timer offset 0x04");
        access(scr1_dmem_pkg::MEM_CMD_RD, scr1_dmem_pkg::MEM_WIDTH_WORD,
               t | scr1_dmem_pkg::TIMER_OFS_CTRL, '0, r, rd);
        check_resp(r, scr1_dmem_pkg::MEM_RESP_RDY_OK, "timer ctrl read");
        check_data(rd, 32'd1, "enable kept after rejected write");
        report_test("timer_rules", err0);
    endtask

    // ----------------------------------------
    // Sequence
    // ----------------------------------------
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        req   = 1'b0;
        cmd   = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        reset_values();
        tcm_rw_merge();
        wishbone_rw();
        count_and_irq();
        timer_access_rules();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: tb.f
design/scr1_dmem_pkg.sv
design/scr1_dmem_router.sv
design/scr1_tcm.sv
design/scr1_timer.sv
design/scr1_dmem_wb.sv
design/scr1_dmem_top.sv
dv/wb_mem_model.sv
dv/tb_scr1_dmem.sv

// File: Bender.yml
package:
  name: scr1_dmem

sources:
  - files:
      - design/scr1_dmem_pkg.sv
      - design/scr1_dmem_router.sv
      - design/scr1_tcm.sv
      - design/scr1_timer.sv
      - design/scr1_dmem_wb.sv
      - design/scr1_dmem_top.sv
  - target: test
    files:
      - dv/wb_mem_model.sv
      - dv/tb_scr1_dmem.sv
